// ==== vlog.f ====
design/usbSpecPkg.sv
design/serialCtrlPkg.sv
design/setupCapture.sv
design/descriptorRom.sv
design/ctrlTfrTracker.sv
design/inPktWriter.sv
design/usbSerialCtrlEndp.sv
verification/tbUsbSerialCtrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the control endpoint testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module tbUsbSerialCtrl -Mdir obj_dir

out=$(./obj_dir/VtbUsbSerialCtrl)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// ==== verification/tbUsbSerialCtrl.sv ====
module tbUsbSerialCtrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] VENDOR_ID = 16'h1337;
  localparam logic [15:0] PRODUCT_ID = 16'hf055;
  localparam int MAX_PKT = 8;
  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int NB_W = $clog2(MAX_PKT + 1);
  localparam int SEED = 17035;
  localparam int N_RANDOM = 40;
  localparam int NUM_TFR = N_RANDOM + 9;        // random plus directed transfers
  localparam int TIMEOUT_CYCLES = NUM_TFR * 200;

  // transaction flags {SETUP, OUT, IN}
  localparam serialCtrlPkg::txnType_t TXN_IDLE = 3'b000;
  localparam serialCtrlPkg::txnType_t TXN_SETUP = 3'b100;
  localparam serialCtrlPkg::txnType_t TXN_OUT = 3'b010;
  localparam serialCtrlPkg::txnType_t TXN_IN = 3'b001;

  logic                     i_clk = 1'b0;
  logic                     i_reset;
  serialCtrlPkg::devAddr_t  o_devAddr;
  logic                     o_er0Ready, i_er0Valid, o_er0Stall, o_er0RdEn;
  logic [IDX_W-1:0]         o_er0RdIdx;
  serialCtrlPkg::byte_t     i_er0RdByte = '0;  // driven by the rx buffer model
  logic [NB_W-1:0]          i_er0RdNBytes;
  logic                     i_et0Ready, o_et0Valid, o_et0Stall, o_et0WrEn;
  logic [IDX_W-1:0]         o_et0WrIdx;
  serialCtrlPkg::byte_t     o_et0WrByte;
  logic [NB_W-1:0]          o_et0WrNBytes;
  serialCtrlPkg::txnType_t  i_txnType;

  serialCtrlPkg::byte_t     rxBuf [MAX_PKT];  // setup payload seen by the DUT
  serialCtrlPkg::byte_t     txBuf [MAX_PKT];  // current IN packet
  logic                     rdReq = 1'b0;
  logic [IDX_W-1:0]         rdReqIdx = '0;
  int                       wrTotal = 0;      // tx buffer writes since start
  int                       cycles = 0;
  int                       nChecks = 0;
  int                       nErrors = 0;
  int unsigned              seedDummy;
  serialCtrlPkg::devAddr_t  expAddr;

  // generic serial device descriptor, byte order as sent on the bus
  serialCtrlPkg::byte_t devModel [18] = '{
    8'd18, 8'd1, 8'h00, 8'h02, 8'd0, 8'd0, 8'd0, 8'(MAX_PKT),
    VENDOR_ID[7:0], VENDOR_ID[15:8], PRODUCT_ID[7:0], PRODUCT_ID[15:8],
    8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd1
  };

  // config, interface, bulk OUT ep1, bulk IN ep1
  serialCtrlPkg::byte_t cfgModel [32] = '{
    8'd9, 8'd2, 8'd32, 8'd0, 8'd1, 8'd1, 8'd0, 8'hC0, 8'd50,
    8'd9, 8'd4, 8'd0, 8'd0, 8'd2, 8'hFF, 8'd0, 8'd0, 8'd0,
    8'd7, 8'd5, 8'h01, 8'd2, 8'(MAX_PKT), 8'(MAX_PKT >> 8), 8'd0,
    8'd7, 8'd5, 8'h81, 8'd2, 8'(MAX_PKT), 8'(MAX_PKT >> 8), 8'd0
  };

  usbSerialCtrlEndp #(
    .VENDOR_ID(VENDOR_ID), .PRODUCT_ID(PRODUCT_ID), .MAX_PKT(MAX_PKT)
  ) dut0 (.*);

  always #4 i_clk = ~i_clk;  // 8 ns period

  // buffer model samples mid-cycle
  always @(negedge i_clk) begin
    rdReq <= o_er0RdEn;
    rdReqIdx <= o_er0RdIdx;
    if (o_et0WrEn) begin
      txBuf[o_et0WrIdx] <= o_et0WrByte;
      wrTotal <= wrTotal + 1;
    end
  end

  always @(posedge i_clk) begin
    if (rdReq) i_er0RdByte <= rxBuf[rdReqIdx];  // one cycle read latency
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      endRun(1'b1);
    end
  end

  task automatic endRun(input logic hung);
    $display("%0d checks, %0d mismatches, %0d timeouts", nChecks, nErrors, hung);
    if (nErrors == 0 && !hung)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  task automatic compareByte(input string name, input serialCtrlPkg::byte_t got,
                             input serialCtrlPkg::byte_t exp);
    nChecks++;
    if (got !== exp) begin
      nErrors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic verifyAddr(input string name, input serialCtrlPkg::devAddr_t got,
                            input serialCtrlPkg::devAddr_t exp);
    nChecks++;
    if (got !== exp) begin
      nErrors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic expectFlag(input string name, input logic got, input logic exp);
    nChecks++;
    if (got !== exp) begin
      nErrors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic serialCtrlPkg::byte_t modelByte(input serialCtrlPkg::byte_t descType,
                                                     input int idx);
    if (descType == 8'd1) return devModel[idx];
    return cfgModel[idx];
  endfunction

  task automatic applyReset();
    i_reset <= 1'b1;
    i_er0Valid <= 1'b0;
    i_et0Ready <= 1'b0;
    i_txnType <= TXN_IDLE;
    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;
    expAddr = '0;
    @(negedge i_clk);
    expectFlag("o_er0RdEn", o_er0RdEn, 1'b0);
    expectFlag("o_et0WrEn", o_et0WrEn, 1'b0);
    expectFlag("o_et0Valid", o_et0Valid, 1'b0);
    expectFlag("o_er0Stall", o_er0Stall, 1'b0);
    expectFlag("o_et0Stall", o_et0Stall, 1'b0);
    expectFlag("o_er0Ready", o_er0Ready, 1'b0);  // idle bus and no transfer
    verifyAddr("o_devAddr", o_devAddr, '0);
  endtask

  // returns mid-cycle once the tracker has decided the transfer kind
  task automatic sendSetup(input serialCtrlPkg::byte_t reqType,
                           input serialCtrlPkg::byte_t request,
                           input logic [15:0] value, input serialCtrlPkg::descLen_t len);
    rxBuf[0] = reqType;
    rxBuf[1] = request;
    rxBuf[2] = value[7:0];
    rxBuf[3] = value[15:8];
    rxBuf[4] = 8'd0;  // wIndex
    rxBuf[5] = 8'd0;
    rxBuf[6] = {1'b0, len};
    rxBuf[7] = 8'd0;
    @(posedge i_clk);
    i_txnType <= TXN_SETUP;
    i_er0Valid <= 1'b1;
    i_er0RdNBytes <= NB_W'(8);
    @(negedge i_clk);
    expectFlag("o_er0Ready", o_er0Ready, 1'b1);
    @(posedge i_clk);
    i_txnType <= TXN_IDLE;
    i_er0Valid <= 1'b0;
    do @(negedge i_clk); while (o_er0RdEn);
    @(posedge i_clk);  // end of the begin pulse cycle, tracker updates here
    @(negedge i_clk);
  endtask

  // host ACKs after a random back-pressure stretch
  task automatic ackIn();
    int gap;
    gap = $urandom % 6;
    repeat (gap) begin
      @(negedge i_clk);
      expectFlag("o_et0Valid", o_et0Valid, 1'b1);
      verifyAddr("o_devAddr", o_devAddr, expAddr);
    end
    @(posedge i_clk);
    i_txnType <= TXN_IN;
    i_et0Ready <= 1'b1;
    @(posedge i_clk);
    i_txnType <= TXN_IDLE;
    i_et0Ready <= 1'b0;
  endtask

  task automatic readDescriptor(input serialCtrlPkg::byte_t descType,
                                input serialCtrlPkg::descLen_t len);
    int total, nPkts, pos, pktLen, xferStart, p, k;
    total = (descType == 8'd1) ? 18 : 32;
    if (int'(len) < total) total = int'(len);
    nPkts = total / MAX_PKT + 1;  // short or zero-length packet closes it
    sendSetup(8'h80, 8'd6, {descType, 8'd0}, len);
    xferStart = wrTotal;
    expectFlag("o_et0Stall", o_et0Stall, 1'b0);
    expectFlag("o_er0Ready", o_er0Ready, 1'b1);  // read transfer open
    pos = 0;
    for (p = 0; p < nPkts; p++) begin
      do @(negedge i_clk); while (!o_et0Valid);
      pktLen = (total - pos > MAX_PKT) ? MAX_PKT : total - pos;
      compareByte("o_et0WrNBytes", 8'(o_et0WrNBytes), 8'(pktLen));
      compareByte("tx write count", 8'(wrTotal - xferStart), 8'(pos + pktLen));
      for (k = 0; k < pktLen; k++)
        compareByte($sformatf("o_et0WrByte[%0d]", pos + k), txBuf[k], modelByte(descType, pos + k));
      pos += pktLen;
      ackIn();
    end
    repeat (3) begin
      @(negedge i_clk);
      expectFlag("o_et0Valid", o_et0Valid, 1'b0);  // nothing left to send
    end
    expectFlag("o_er0Ready", o_er0Ready, 1'b1);
    @(posedge i_clk);  // zero-length status OUT
    i_txnType <= TXN_OUT;
    i_er0Valid <= 1'b1;
    i_er0RdNBytes <= '0;
    @(posedge i_clk);
    i_txnType <= TXN_IDLE;
    i_er0Valid <= 1'b0;
    @(negedge i_clk);
    expectFlag("o_er0Ready", o_er0Ready, 1'b0);
  endtask

  task automatic stallRequest(input logic dirIn);
    serialCtrlPkg::byte_t request, descType;
    int n;
    if (dirIn && ($urandom % 2 == 0)) begin
      request = 8'd6;  // GET_DESCRIPTOR, unknown type
      do descType = 8'($urandom); while (descType == 8'd1 || descType == 8'd2);
    end else begin
      do request = 8'($urandom % 16); while (request == 8'd5 || request == 8'd6);
      descType = 8'($urandom);
    end
    sendSetup({dirIn, 7'd0}, request, {descType, 8'($urandom)}, 7'(1 + $urandom % 127));
    expectFlag("o_et0Stall", o_et0Stall, dirIn);
    expectFlag("o_er0Stall", o_er0Stall, !dirIn);
    if (dirIn) expectFlag("o_et0Valid", o_et0Valid, 1'b0);
    n = 4 + $urandom % 8;
    repeat (n) begin
      @(negedge i_clk);
      expectFlag("o_et0Valid", o_et0Valid, 1'b0);
      expectFlag("o_er0Ready", o_er0Ready, 1'b0);
      expectFlag("o_et0Stall", o_et0Stall, dirIn);  // held until next setup
      expectFlag("o_er0Stall", o_er0Stall, !dirIn);
    end
  endtask

  task automatic setAddress(input serialCtrlPkg::devAddr_t addr);
    sendSetup(8'h00, 8'd5, {8'd0, 1'b0, addr}, 7'd0);
    expectFlag("o_et0Valid", o_et0Valid, 1'b1);  // zero-length status IN
    compareByte("o_et0WrNBytes", 8'(o_et0WrNBytes), 8'd0);
    expectFlag("o_er0Ready", o_er0Ready, 1'b0);
    verifyAddr("o_devAddr", o_devAddr, expAddr);  // old address until ACK
    ackIn();
    expAddr = addr;
    @(negedge i_clk);
    verifyAddr("o_devAddr", o_devAddr, expAddr);
    expectFlag("o_et0Valid", o_et0Valid, 1'b0);
  endtask

  initial begin
    i_reset = 1'b1;
    i_er0Valid = 1'b0;
    i_er0RdNBytes = '0;
    i_et0Ready = 1'b0;
    i_txnType = TXN_IDLE;
    seedDummy = $urandom(SEED);
    applyReset();
    readDescriptor(8'd1, 7'd18);
    readDescriptor(8'd1, 7'd16);   // exact multiple ends in a zlp
    readDescriptor(8'd2, 7'd32);
    readDescriptor(8'd2, 7'd100);  // wLength beyond descriptor
    setAddress(7'h2A);
    stallRequest(1'b1);
    stallRequest(1'b0);
    for (int t = 0; t < N_RANDOM; t++) begin
      case ($urandom % 5)
        0: readDescriptor(8'd1, 7'(1 + $urandom % 127));
        1: readDescriptor(8'd2, 7'(1 + $urandom % 127));
        2: stallRequest(1'b1);
        3: stallRequest(1'b0);
        default: setAddress(7'($urandom));
      endcase
    end
    @(posedge i_clk);
    applyReset();  // clears a nonzero address
    setAddress(7'($urandom));
    readDescriptor(8'd1, 7'd64);
    endRun(1'b0);
  end

endmodule

// ==== design/usbSerialCtrlEndp.sv ====
module usbSerialCtrlEndp #(
  parameter logic [15:0] VENDOR_ID  = 16'h1337,
  parameter logic [15:0] PRODUCT_ID = 16'hf055,
  parameter int          MAX_PKT    = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  output serialCtrlPkg::devAddr_t      o_devAddr,
  output logic                         o_er0Ready,   // host to device
  input  logic                         i_er0Valid,
  output logic                         o_er0Stall,
  output logic                         o_er0RdEn,    // rx buffer reads
  output logic [$clog2(MAX_PKT)-1:0]   o_er0RdIdx,
  input  serialCtrlPkg::byte_t         i_er0RdByte,
  input  logic [$clog2(MAX_PKT+1)-1:0] i_er0RdNBytes,
  input  logic                         i_et0Ready,   // ACK or STALL seen
  output logic                         o_et0Valid,
  output logic                         o_et0Stall,
  output logic                         o_et0WrEn,    // tx buffer writes
  output logic [$clog2(MAX_PKT)-1:0]   o_et0WrIdx,
  output serialCtrlPkg::byte_t         o_et0WrByte,
  output logic [$clog2(MAX_PKT+1)-1:0] o_et0WrNBytes,
  input  serialCtrlPkg::txnType_t      i_txnType     // {SETUP, OUT, IN}
);

  logic erAccepted, etAccepted, beginCtrlTfr, dirIn, descFound;
  serialCtrlPkg::byte_t     bRequest, descByte;
  logic [15:0]              wValue;
  serialCtrlPkg::descLen_t  wLength0, descLen, descAddr;
  serialCtrlPkg::ctrlTfr_t  tfr;

  assign erAccepted = o_er0Ready && i_er0Valid;
  assign etAccepted = o_et0Valid && i_et0Ready;
  // take every setup payload, and the zero-length status OUT of a read
  assign o_er0Ready = i_txnType[2] || (tfr == serialCtrlPkg::TFR_READ);

  setupCapture #(.MAX_PKT(MAX_PKT)) u_setup (
    .i_clk, .i_reset, .i_erAccepted(erAccepted), .i_isSetup(i_txnType[2]),
    .i_er0RdByte, .i_er0RdNBytes, .o_er0RdEn, .o_er0RdIdx,
    .o_bRequest(bRequest), .o_wValue(wValue), .o_wLength0(wLength0),
    .o_dirIn(dirIn), .o_beginCtrlTfr(beginCtrlTfr)
  );

  descriptorRom #(.VENDOR_ID(VENDOR_ID), .PRODUCT_ID(PRODUCT_ID), .MAX_PKT(MAX_PKT)) u_rom (
    .i_descType(wValue[15:8]), .i_addr(descAddr),
    .o_descFound(descFound), .o_descLen(descLen), .o_descByte(descByte)
  );

  ctrlTfrTracker u_tracker (
    .i_clk, .i_reset, .i_beginCtrlTfr(beginCtrlTfr), .i_bRequest(bRequest),
    .i_wValueLow(wValue[7:0]), .i_wLength0(wLength0), .i_dirIn(dirIn),
    .i_descFound(descFound),
    .i_zeroInSent(etAccepted && i_txnType[0]),    // IN status stage
    .i_outAccepted(erAccepted && i_txnType[1]),   // OUT status stage
    .o_tfr(tfr), .o_er0Stall, .o_et0Stall, .o_devAddr
  );

  inPktWriter #(.MAX_PKT(MAX_PKT)) u_writer (
    .i_clk, .i_reset, .i_tfr(tfr), .i_beginCtrlTfr(beginCtrlTfr),
    .i_etAccepted(etAccepted), .i_wLength0(wLength0), .i_descLen(descLen),
    .i_descByte(descByte), .o_descAddr(descAddr), .o_et0WrEn, .o_et0WrIdx,
    .o_et0WrByte, .o_et0WrNBytes, .o_et0Valid
  );

endmodule

// ==== design/inPktWriter.sv ====
module inPktWriter #(
  parameter int MAX_PKT = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  serialCtrlPkg::ctrlTfr_t      i_tfr,
  input  logic                         i_beginCtrlTfr,
  input  logic                         i_etAccepted,
  input  serialCtrlPkg::descLen_t      i_wLength0,
  input  serialCtrlPkg::descLen_t      i_descLen,
  input  serialCtrlPkg::byte_t         i_descByte,
  output serialCtrlPkg::descLen_t      o_descAddr,
  output logic                         o_et0WrEn,
  output logic [$clog2(MAX_PKT)-1:0]   o_et0WrIdx,
  output serialCtrlPkg::byte_t         o_et0WrByte,
  output logic [$clog2(MAX_PKT+1)-1:0] o_et0WrNBytes,
  output logic                         o_et0Valid
);

  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int NB_W = $clog2(MAX_PKT + 1);
  localparam int NPKT_W = $clog2(128 / MAX_PKT + 1);  // wLength under 128

  serialCtrlPkg::wrState_t  state;
  serialCtrlPkg::descLen_t  bytesWritten;  // across the whole transfer
  serialCtrlPkg::descLen_t  nBytesToSend;
  logic [NB_W-1:0]          wrNBytes;      // within current packet
  logic [NPKT_W-1:0]        pktsSent;
  logic                     inRead, pktFull, descDone, pktsRemain;

  assign inRead = (i_tfr == serialCtrlPkg::TFR_READ);
  // short descriptor ends early, short wLength truncates
  assign nBytesToSend = (i_wLength0 < i_descLen) ? i_wLength0 : i_descLen;
  assign o_et0WrEn = (state == serialCtrlPkg::WR_FILL) && inRead && (bytesWritten != nBytesToSend);
  assign pktFull = (o_et0WrIdx == IDX_W'(MAX_PKT - 1));  // MAX_PKT is a power of 2
  assign descDone = (bytesWritten + 7'd1 == nBytesToSend);
  // one extra packet beyond full ones, short or zero-length
  assign pktsRemain = (int'(pktsSent) * MAX_PKT) <= int'(nBytesToSend);

  assign o_descAddr = bytesWritten;
  assign o_et0WrByte = i_descByte;
  assign o_et0WrIdx = wrNBytes[IDX_W-1:0];
  assign o_et0WrNBytes = inRead ? wrNBytes : '0;  // status stages are zero-length
  assign o_et0Valid = inRead ? ((state == serialCtrlPkg::WR_WAIT) && pktsRemain)
                             : ((i_tfr == serialCtrlPkg::TFR_NODATA) ||
                                (i_tfr == serialCtrlPkg::TFR_WRITE));

  always_ff @(posedge i_clk) begin
    if (i_reset || i_beginCtrlTfr) begin
      state <= serialCtrlPkg::WR_IDLE;
      bytesWritten <= '0;
      wrNBytes <= '0;
      pktsSent <= '0;
    end else begin
      if (o_et0WrEn) begin
        bytesWritten <= bytesWritten + 7'd1;
        wrNBytes <= wrNBytes + 1'b1;
      end
      case (state)
        serialCtrlPkg::WR_IDLE: if (inRead) state <= serialCtrlPkg::WR_FILL;
        serialCtrlPkg::WR_FILL: begin
          if (!inRead) state <= serialCtrlPkg::WR_IDLE;  // stalled or aborted
          else if (!o_et0WrEn || pktFull || descDone) state <= serialCtrlPkg::WR_WAIT;
        end
        serialCtrlPkg::WR_WAIT: begin
          if (!inRead) begin
            state <= serialCtrlPkg::WR_IDLE;
          end else if (i_etAccepted) begin
            state <= serialCtrlPkg::WR_FILL;  // next packet
            pktsSent <= pktsSent + 1'b1;
            wrNBytes <= '0;
          end
        end
        default: state <= serialCtrlPkg::WR_IDLE;
      endcase
    end
  end

  // tx buffer never rewritten under a packet the host may be reading
  a_wrOnlyInFill: assert property (@(posedge i_clk) disable iff (i_reset)
    o_et0WrEn |-> (state == serialCtrlPkg::WR_FILL) && !o_et0Valid);

endmodule

// ==== design/ctrlTfrTracker.sv ====
module ctrlTfrTracker (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_beginCtrlTfr,
  input  serialCtrlPkg::byte_t     i_bRequest,
  input  serialCtrlPkg::byte_t     i_wValueLow,
  input  serialCtrlPkg::descLen_t  i_wLength0,
  input  logic                     i_dirIn,
  input  logic                     i_descFound,
  input  logic                     i_zeroInSent,
  input  logic                     i_outAccepted,
  output serialCtrlPkg::ctrlTfr_t  o_tfr,
  output logic                     o_er0Stall,
  output logic                     o_et0Stall,
  output serialCtrlPkg::devAddr_t  o_devAddr
);

  serialCtrlPkg::ctrlTfr_t  nextKind;
  serialCtrlPkg::devAddr_t  newAddr;  // held until status stage completes
  logic                     setAddress;
  logic                     getDescriptor;
  logic                     supported;
  logic                     setAddrPending;
  logic                     applyAddr;

  assign setAddress = (i_bRequest == usbSpecPkg::BREQUEST_SET_ADDRESS);
  assign getDescriptor = (i_bRequest == usbSpecPkg::BREQUEST_GET_DESCRIPTOR);
  // only two requests answered, descriptor type decoded in the rom
  assign supported = setAddress || (getDescriptor && i_descFound);

  // new address only after the zero-length IN of SET_ADDRESS is ACKed
  assign applyAddr = setAddrPending && (o_tfr == serialCtrlPkg::TFR_NODATA) && i_zeroInSent;

  always_comb begin
    if (i_wLength0 == '0)
      nextKind = serialCtrlPkg::TFR_NODATA;
    else if (i_dirIn)
      nextKind = serialCtrlPkg::TFR_READ;
    else
      nextKind = serialCtrlPkg::TFR_WRITE;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_tfr <= serialCtrlPkg::TFR_NONE;
      o_et0Stall <= 1'b0;
      o_er0Stall <= 1'b0;
      setAddrPending <= 1'b0;
      o_devAddr <= '0;
    end else if (i_beginCtrlTfr) begin
      // host may abandon a transfer, latest setup always wins
      o_tfr <= nextKind;
      o_et0Stall <= (nextKind == serialCtrlPkg::TFR_READ) && !supported;
      o_er0Stall <= (nextKind == serialCtrlPkg::TFR_WRITE) && !supported;
      setAddrPending <= setAddress && (nextKind == serialCtrlPkg::TFR_NODATA);
    end else begin
      if (o_et0Stall || o_er0Stall) begin
        o_tfr <= serialCtrlPkg::TFR_NONE;  // stall answers every stage
      end else begin
        case (o_tfr)
          serialCtrlPkg::TFR_NODATA,
          serialCtrlPkg::TFR_WRITE: if (i_zeroInSent) o_tfr <= serialCtrlPkg::TFR_NONE;
          serialCtrlPkg::TFR_READ:  if (i_outAccepted) o_tfr <= serialCtrlPkg::TFR_NONE;
          default: ;
        endcase
      end
      if (applyAddr) begin
        o_devAddr <= newAddr;  // sticky until next SET_ADDRESS
        setAddrPending <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_beginCtrlTfr && setAddress) newAddr <= i_wValueLow[6:0];
  end

  a_oneStall: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_et0Stall && o_er0Stall));

endmodule

// ==== design/descriptorRom.sv ====
module descriptorRom #(
  parameter logic [15:0] VENDOR_ID  = 16'h1337,
  parameter logic [15:0] PRODUCT_ID = 16'hf055,
  parameter int          MAX_PKT    = 8
) (
  input  serialCtrlPkg::byte_t     i_descType,
  input  serialCtrlPkg::descLen_t  i_addr,
  output logic                     o_descFound,
  output serialCtrlPkg::descLen_t  o_descLen,
  output serialCtrlPkg::byte_t     o_descByte
);

  localparam int DEV_LEN = usbSpecPkg::DEVICE_BLENGTH;
  localparam int CFG_LEN = usbSpecPkg::CONFIG_WTOTALLENGTH;

  // byte 0 in the low bits, multi-byte fields land little-endian
  localparam logic [8*DEV_LEN-1:0] DEV_ROM = {
    8'd1,                                  // bNumConfigurations
    8'd0, 8'd0, 8'd0,                      // no string descriptors
    16'h0000,                              // bcdDevice
    PRODUCT_ID,
    VENDOR_ID,
    8'(MAX_PKT),                           // bMaxPacketSize0
    8'd0, 8'd0,                            // protocol, subclass
    usbSpecPkg::BASECLASS_UNKNOWN,         // class from interface
    16'h0200,                              // usb 2.0
    usbSpecPkg::BDESCRIPTORTYPE_DEVICE,
    8'(DEV_LEN)
  };

  localparam logic [8*CFG_LEN-1:0] CFG_ROM = {
    // bulk IN, ep 1
    8'd0, 16'(MAX_PKT), usbSpecPkg::ENDPTYPE_BULK, 8'h81,
    usbSpecPkg::BDESCRIPTORTYPE_ENDPOINT, 8'd7,
    // bulk OUT, ep 1
    8'd0, 16'(MAX_PKT), usbSpecPkg::ENDPTYPE_BULK, 8'h01,
    usbSpecPkg::BDESCRIPTORTYPE_ENDPOINT, 8'd7,
    // interface 0, two endpoints, vendor class
    8'd0, 8'd0, 8'd0, usbSpecPkg::BASECLASS_VENDOR, 8'd2, 8'd0, 8'd0,
    usbSpecPkg::BDESCRIPTORTYPE_INTERFACE, 8'd9,
    // configuration 1
    8'd50,                                 // 100mA
    8'hC0,                                 // self and bus powered
    8'd0, 8'd1, 8'd1,                      // no string, value 1, one interface
    16'(CFG_LEN),
    usbSpecPkg::BDESCRIPTORTYPE_CONFIGURATION,
    8'd9
  };

  always_comb begin
    o_descFound = 1'b0;
    o_descLen = '0;
    o_descByte = '0;
    if (i_descType == usbSpecPkg::BDESCRIPTORTYPE_DEVICE) begin
      o_descFound = 1'b1;
      o_descLen = 7'(DEV_LEN);
      if (int'(i_addr) < DEV_LEN) o_descByte = DEV_ROM[8*i_addr +: 8];
    end else if (i_descType == usbSpecPkg::BDESCRIPTORTYPE_CONFIGURATION) begin
      o_descFound = 1'b1;
      o_descLen = 7'(CFG_LEN);
      if (int'(i_addr) < CFG_LEN) o_descByte = CFG_ROM[8*i_addr +: 8];
    end
  end

endmodule

// ==== design/setupCapture.sv ====
module setupCapture #(
  parameter int MAX_PKT = 8
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_erAccepted,
  input  logic                         i_isSetup,
  input  serialCtrlPkg::byte_t         i_er0RdByte,
  input  logic [$clog2(MAX_PKT+1)-1:0] i_er0RdNBytes,
  output logic                         o_er0RdEn,
  output logic [$clog2(MAX_PKT)-1:0]   o_er0RdIdx,
  output serialCtrlPkg::byte_t         o_bRequest,
  output logic [15:0]                  o_wValue,
  output serialCtrlPkg::descLen_t      o_wLength0,
  output logic                         o_dirIn,
  output logic                         o_beginCtrlTfr
);

  localparam int IDX_W = $clog2(MAX_PKT);
  localparam int NB_W = $clog2(MAX_PKT + 1);

  logic [NB_W-1:0]  rdNBytes;     // payload size latched at accept
  logic [NB_W-1:0]  rdIdx;
  logic             push;         // rd data valid this cycle
  logic [IDX_W-1:0] pushIdx;
  logic             setupInflight;
  logic             finalPush;

  assign o_er0RdEn = (rdNBytes != rdIdx);
  assign o_er0RdIdx = rdIdx[IDX_W-1:0];
  assign finalPush = push && !o_er0RdEn;  // last byte arrives, no more reads
  assign o_beginCtrlTfr = setupInflight && finalPush;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rdNBytes <= '0;
      rdIdx <= '0;
      push <= 1'b0;
      setupInflight <= 1'b0;
    end else begin
      push <= o_er0RdEn;  // buffer answers one cycle later
      if (i_erAccepted) begin
        rdNBytes <= i_er0RdNBytes;
        rdIdx <= '0;
        setupInflight <= i_isSetup;  // data-stage payloads do not start a transfer
      end else begin
        if (o_er0RdEn) rdIdx <= rdIdx + 1'b1;
        if (finalPush) setupInflight <= 1'b0;
      end
    end
  end

  // request fields, wIndex and wLength high byte are not kept
  always_ff @(posedge i_clk) begin
    pushIdx <= o_er0RdIdx;
    if (push && setupInflight) begin
      case (pushIdx)
        'd0: o_dirIn <= i_er0RdByte[7];  // bmRequestType direction
        'd1: o_bRequest <= i_er0RdByte;
        'd2: o_wValue[7:0] <= i_er0RdByte;
        'd3: o_wValue[15:8] <= i_er0RdByte;  // descriptor type
        'd6: o_wLength0 <= i_er0RdByte[6:0];
        default: ;
      endcase
    end
  end

  a_rdIdxInRange: assert property (@(posedge i_clk) disable iff (i_reset)
    rdIdx <= rdNBytes);

endmodule

// ==== design/serialCtrlPkg.sv ====
package serialCtrlPkg;

  typedef logic [7:0] byte_t;     // one payload byte
  typedef logic [6:0] devAddr_t;  // usb device address
  typedef logic [6:0] descLen_t;  // descriptor or request length, under 128
  typedef logic [2:0] txnType_t;  // flags {SETUP, OUT, IN}

  // kind of the control transfer in progress
  typedef enum logic [1:0] {
    TFR_NONE,
    TFR_NODATA,  // setup, status in
    TFR_READ,    // setup, data in, status out
    TFR_WRITE    // setup, data out, status in
  } ctrlTfr_t;

  // IN packet writer
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_FILL,  // copying descriptor bytes into tx buffer
    WR_WAIT   // packet ready, waiting on ACK
  } wrState_t;

endpackage

// ==== design/usbSpecPkg.sv ====
package usbSpecPkg;

  // standard device request codes, bRequest
  localparam logic [7:0] BREQUEST_SET_ADDRESS    = 8'd5;
  localparam logic [7:0] BREQUEST_GET_DESCRIPTOR = 8'd6;

  // descriptor types, wValue high byte of GET_DESCRIPTOR
  localparam logic [7:0] BDESCRIPTORTYPE_DEVICE        = 8'd1;
  localparam logic [7:0] BDESCRIPTORTYPE_CONFIGURATION = 8'd2;
  localparam logic [7:0] BDESCRIPTORTYPE_INTERFACE     = 8'd4;
  localparam logic [7:0] BDESCRIPTORTYPE_ENDPOINT      = 8'd5;

  // class codes
  localparam logic [7:0] BASECLASS_UNKNOWN = 8'd0;   // defer to interface descriptor
  localparam logic [7:0] BASECLASS_VENDOR  = 8'hFF;  // usbserial matches on vid:pid

  // endpoint bmAttributes transfer type
  localparam logic [7:0] ENDPTYPE_BULK = 8'd2;

  // descriptor sizes in bytes
  // config total = config + interface + 2 endpoints
  localparam int DEVICE_BLENGTH      = 18;
  localparam int CONFIG_WTOTALLENGTH = 9 + 9 + 7 + 7;

endpackage
